//--- hw/csr_pkg.sv
package csr_pkg;

  ////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////

  typedef logic [31:0] csr_data_t;
  typedef logic [11:0] csr_addr_t;

  // Bit 5 flags an interrupt, bits 4:0 hold the exception code
  typedef logic [5:0] csr_cause_t;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  ////////////////////////////////////////
  // CSR addresses
  ////////////////////////////////////////

  localparam csr_addr_t CSR_MSTATUS   = 12'h300;
  localparam csr_addr_t CSR_MIE       = 12'h304;
  localparam csr_addr_t CSR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_DCSR      = 12'h7B0;
  localparam csr_addr_t CSR_DPC       = 12'h7B1;
  localparam csr_addr_t CSR_DSCRATCH0 = 12'h7B2;
  localparam csr_addr_t CSR_DSCRATCH1 = 12'h7B3;

  ////////////////////////////////////////
  // Request, control and response
  ////////////////////////////////////////

  typedef struct packed {
    logic      valid;
    csr_op_e   op;
    csr_addr_t addr;
    csr_data_t wdata;
  } csr_req_t;

  // Strobes from the write-back controller
  typedef struct packed {
    logic       kill_wb;
    logic       halt_wb;
    logic       save_cause;
    logic       restore_mret;
    logic       debug_entry;
    logic [2:0] debug_cause;
    csr_data_t  pc;
  } csr_ctrl_t;

  typedef struct packed {
    logic      hit;
    csr_data_t rdata;
  } bank_rsp_t;

  typedef struct packed {
    logic      valid;
    logic      illegal;
    csr_data_t rdata;
  } csr_rsp_t;

  // New register value for a CSR instruction, before field masking
  function automatic csr_data_t csr_rmw(csr_op_e op, csr_data_t old_val, csr_data_t wdata);
    csr_data_t res;
    case (op)
      CSR_OP_WRITE: res = wdata;
      CSR_OP_SET:   res = old_val | wdata;
      CSR_OP_CLEAR: res = old_val & ~wdata;
      default:      res = old_val;
    endcase
    return res;
  endfunction

  // A read never writes, and a set or clear with all-zero data is a pure read
  function automatic logic csr_wr_req(csr_req_t req);
    logic set_clr;
    set_clr = (req.op == CSR_OP_SET) || (req.op == CSR_OP_CLEAR);
    return (req.op != CSR_OP_READ) && !(set_clr && (req.wdata == '0));
  endfunction

endpackage

//--- hw/csr_machine_bank.sv
`timescale 1ns/1ps

module csr_machine_bank #(
  parameter csr_pkg::csr_data_t MTVEC_RST = 32'h0000_0100
) (
  input  logic                clk,
  input  logic                rst_i,
  input  csr_pkg::csr_req_t   req_i,
  input  csr_pkg::csr_ctrl_t  ctrl_i,
  input  csr_pkg::csr_cause_t trap_cause_i,
  output csr_pkg::bank_rsp_t  rsp_o,
  output csr_pkg::csr_data_t  mepc_o,
  output csr_pkg::csr_data_t  mtvec_o
);

  // Writable fields of each register
  localparam csr_pkg::csr_data_t MSTATUS_MASK = 32'h0000_0088;
  localparam csr_pkg::csr_data_t MIE_MASK     = 32'h0000_0888;
  localparam csr_pkg::csr_data_t MTVEC_MASK   = 32'hFFFF_FFFC;
  localparam csr_pkg::csr_data_t MEPC_MASK    = 32'hFFFF_FFFE;
  localparam csr_pkg::csr_data_t MCAUSE_MASK  = 32'h8000_001F;

  localparam int MIE_BIT  = 3;
  localparam int MPIE_BIT = 7;

  csr_pkg::csr_data_t mstatus_q;
  csr_pkg::csr_data_t mie_q;
  csr_pkg::csr_data_t mtvec_q;
  csr_pkg::csr_data_t mscratch_q;
  csr_pkg::csr_data_t mepc_q;
  csr_pkg::csr_data_t mcause_q;

  logic               hit;
  logic               perform;
  logic               wr_en;
  csr_pkg::csr_data_t old_val;
  csr_pkg::csr_data_t wval;

  ////////////////////////////////////////
  // Address decode and read mux
  ////////////////////////////////////////

  always_comb begin
    hit     = 1'b1;
    old_val = '0;
    case (req_i.addr)
      csr_pkg::CSR_MSTATUS:  old_val = mstatus_q;
      csr_pkg::CSR_MIE:      old_val = mie_q;
      csr_pkg::CSR_MTVEC:    old_val = mtvec_q;
      csr_pkg::CSR_MSCRATCH: old_val = mscratch_q;
      csr_pkg::CSR_MEPC:     old_val = mepc_q;
      csr_pkg::CSR_MCAUSE:   old_val = mcause_q;
      default:               hit     = 1'b0;
    endcase
  end

  assign perform = req_i.valid && !ctrl_i.kill_wb && !ctrl_i.halt_wb;
  assign wr_en   = perform && hit && csr_pkg::csr_wr_req(req_i);
  assign wval    = csr_pkg::csr_rmw(req_i.op, old_val, req_i.wdata);

  assign rsp_o   = '{hit: hit, rdata: old_val};
  assign mepc_o  = mepc_q;
  assign mtvec_o = mtvec_q;

  ////////////////////////////////////////
  // Register update
  ////////////////////////////////////////

  // Trap save and mret only override writes to the registers they touch
  always_ff @(posedge clk) begin
    if (rst_i) begin
      mstatus_q  <= '0;
      mie_q      <= '0;
      mtvec_q    <= MTVEC_RST & MTVEC_MASK;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      if (ctrl_i.save_cause) begin
        mstatus_q[MPIE_BIT] <= mstatus_q[MIE_BIT];
        mstatus_q[MIE_BIT]  <= 1'b0;
      end else if (ctrl_i.restore_mret) begin
        mstatus_q[MIE_BIT]  <= mstatus_q[MPIE_BIT];
        mstatus_q[MPIE_BIT] <= 1'b1;
      end else if (wr_en && (req_i.addr == csr_pkg::CSR_MSTATUS)) begin
        mstatus_q <= wval & MSTATUS_MASK;
      end

      if (ctrl_i.save_cause) begin
        mepc_q   <= ctrl_i.pc & MEPC_MASK;
        mcause_q <= {trap_cause_i[5], 26'b0, trap_cause_i[4:0]};
      end else begin
        if (wr_en && (req_i.addr == csr_pkg::CSR_MEPC)) begin
          mepc_q <= wval & MEPC_MASK;
        end
        if (wr_en && (req_i.addr == csr_pkg::CSR_MCAUSE)) begin
          mcause_q <= wval & MCAUSE_MASK;
        end
      end

      if (wr_en && (req_i.addr == csr_pkg::CSR_MIE)) begin
        mie_q <= wval & MIE_MASK;
      end
      if (wr_en && (req_i.addr == csr_pkg::CSR_MTVEC)) begin
        mtvec_q <= wval & MTVEC_MASK;
      end
      if (wr_en && (req_i.addr == csr_pkg::CSR_MSCRATCH)) begin
        mscratch_q <= wval;
      end
    end
  end

  ////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////

  // A killed or halted instruction must leave the whole bank untouched
  a_kill_halt_stable: assert property (@(posedge clk) disable iff (rst_i)
      (ctrl_i.kill_wb || ctrl_i.halt_wb) && !ctrl_i.save_cause && !ctrl_i.restore_mret
      |=> $stable({mstatus_q, mie_q, mtvec_q, mscratch_q, mepc_q, mcause_q}))
    else $error("machine CSR changed while write-back was killed or halted");

  a_save_restore_excl: assert property (@(posedge clk) disable iff (rst_i)
      !(ctrl_i.save_cause && ctrl_i.restore_mret))
    else $error("trap save and mret restore in the same cycle");

  a_set_clear_zero: assert property (@(posedge clk) disable iff (rst_i)
      perform && hit && (req_i.wdata == '0) &&
      ((req_i.op == csr_pkg::CSR_OP_SET) || (req_i.op == csr_pkg::CSR_OP_CLEAR)) &&
      !ctrl_i.save_cause && !ctrl_i.restore_mret
      |=> $stable({mstatus_q, mie_q, mtvec_q, mscratch_q, mepc_q, mcause_q}))
    else $error("machine CSR changed after set or clear with zero data");

endmodule

//--- hw/csr_debug_bank.sv
`timescale 1ns/1ps

module csr_debug_bank #(
  parameter bit DEBUG = 1'b1
) (
  input  logic               clk,
  input  logic               rst_i,
  input  csr_pkg::csr_req_t  req_i,
  input  csr_pkg::csr_ctrl_t ctrl_i,
  output csr_pkg::bank_rsp_t rsp_o,
  output csr_pkg::csr_data_t dpc_o
);

  if (DEBUG) begin : gen_debug

    // Bits 31:28 hold the debug version 4, only ebreakm and step are writable
    localparam csr_pkg::csr_data_t DCSR_RST   = 32'h4000_0000;
    localparam csr_pkg::csr_data_t DCSR_WMASK = 32'h0000_8004;
    localparam csr_pkg::csr_data_t DPC_MASK   = 32'hFFFF_FFFE;

    csr_pkg::csr_data_t dcsr_q;
    csr_pkg::csr_data_t dpc_q;
    csr_pkg::csr_data_t dscratch0_q;
    csr_pkg::csr_data_t dscratch1_q;

    logic               hit;
    logic               perform;
    logic               wr_en;
    csr_pkg::csr_data_t old_val;
    csr_pkg::csr_data_t wval;

    always_comb begin
      hit     = 1'b1;
      old_val = '0;
      case (req_i.addr)
        csr_pkg::CSR_DCSR:      old_val = dcsr_q;
        csr_pkg::CSR_DPC:       old_val = dpc_q;
        csr_pkg::CSR_DSCRATCH0: old_val = dscratch0_q;
        csr_pkg::CSR_DSCRATCH1: old_val = dscratch1_q;
        default:                hit     = 1'b0;
      endcase
    end

    assign perform = req_i.valid && !ctrl_i.kill_wb && !ctrl_i.halt_wb;
    assign wr_en   = perform && hit && csr_pkg::csr_wr_req(req_i);
    assign wval    = csr_pkg::csr_rmw(req_i.op, old_val, req_i.wdata);

    assign rsp_o = '{hit: hit, rdata: old_val};
    assign dpc_o = dpc_q;

    // Debug entry owns dpc and dcsr for the cycle it fires
    always_ff @(posedge clk) begin
      if (rst_i) begin
        dcsr_q      <= DCSR_RST;
        dpc_q       <= '0;
        dscratch0_q <= '0;
        dscratch1_q <= '0;
      end else begin
        if (ctrl_i.debug_entry) begin
          dcsr_q[8:6] <= ctrl_i.debug_cause;
          dpc_q       <= ctrl_i.pc & DPC_MASK;
        end else begin
          if (wr_en && (req_i.addr == csr_pkg::CSR_DCSR)) begin
            dcsr_q <= (dcsr_q & ~DCSR_WMASK) | (wval & DCSR_WMASK);
          end
          if (wr_en && (req_i.addr == csr_pkg::CSR_DPC)) begin
            dpc_q <= wval & DPC_MASK;
          end
        end
        if (wr_en && (req_i.addr == csr_pkg::CSR_DSCRATCH0)) begin
          dscratch0_q <= wval;
        end
        if (wr_en && (req_i.addr == csr_pkg::CSR_DSCRATCH1)) begin
          dscratch1_q <= wval;
        end
      end
    end

    a_kill_halt_stable: assert property (@(posedge clk) disable iff (rst_i)
        (ctrl_i.kill_wb || ctrl_i.halt_wb) && !ctrl_i.debug_entry
        |=> $stable({dcsr_q, dpc_q, dscratch0_q, dscratch1_q}))
      else $error("debug CSR changed while write-back was killed or halted");

    a_set_clear_zero: assert property (@(posedge clk) disable iff (rst_i)
        perform && hit && (req_i.wdata == '0) && !ctrl_i.debug_entry &&
        ((req_i.op == csr_pkg::CSR_OP_SET) || (req_i.op == csr_pkg::CSR_OP_CLEAR))
        |=> $stable({dcsr_q, dpc_q, dscratch0_q, dscratch1_q}))
      else $error("debug CSR changed after set or clear with zero data");

  end else begin : gen_no_debug

    // Without debug support the bank never claims an address
    assign rsp_o = '{hit: 1'b0, rdata: '0};
    assign dpc_o = '0;

  end

endmodule

//--- hw/csr_resp.sv
`timescale 1ns/1ps

module csr_resp #(
  parameter bit DEBUG = 1'b1
) (
  input  logic               clk,
  input  logic               rst_i,
  input  logic               valid_i,
  input  logic               kill_i,
  input  logic               halt_i,
  input  csr_pkg::bank_rsp_t mach_i,
  input  csr_pkg::bank_rsp_t dbg_i,
  output csr_pkg::csr_rsp_t  rsp_o
);

  logic               perform;
  logic               dbg_hit;
  logic               any_hit;
  csr_pkg::csr_data_t sel_rdata;
  csr_pkg::csr_rsp_t  rsp_q;

  assign perform = valid_i && !kill_i && !halt_i;
  assign dbg_hit = DEBUG && dbg_i.hit;
  assign any_hit = mach_i.hit || dbg_hit;

  // Unmapped addresses read as zero
  always_comb begin
    sel_rdata = '0;
    if (mach_i.hit) begin
      sel_rdata = mach_i.rdata;
    end else if (dbg_hit) begin
      sel_rdata = dbg_i.rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      rsp_q <= '0;
    end else begin
      rsp_q.valid <= perform;
      if (perform) begin
        rsp_q.illegal <= !any_hit;
        rsp_q.rdata   <= sel_rdata;
      end
    end
  end

  assign rsp_o = rsp_q;

  // Address maps of the two banks must not overlap
  a_single_hit: assert property (@(posedge clk) disable iff (rst_i)
      !(mach_i.hit && dbg_hit))
    else $error("machine and debug banks hit the same address");

endmodule

//--- hw/csr_unit.sv
`timescale 1ns/1ps

module csr_unit #(
  parameter bit                 DEBUG     = 1'b1,
  parameter csr_pkg::csr_data_t MTVEC_RST = 32'h0000_0100
) (
  input  logic                clk,
  input  logic                rst_i,
  input  csr_pkg::csr_req_t   csr_req_i,
  input  csr_pkg::csr_ctrl_t  ctrl_i,
  input  csr_pkg::csr_cause_t trap_cause_i,
  output csr_pkg::csr_rsp_t   rsp_o,
  output csr_pkg::csr_data_t  mepc_o,
  output csr_pkg::csr_data_t  mtvec_o,
  output csr_pkg::csr_data_t  dpc_o
);

  csr_pkg::bank_rsp_t mach_rsp;
  csr_pkg::bank_rsp_t dbg_rsp;

  ////////////////////////////////////////
  // Register banks
  ////////////////////////////////////////

  csr_machine_bank #(
    .MTVEC_RST (MTVEC_RST)
  ) u_machine_bank (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_i        (csr_req_i),
    .ctrl_i       (ctrl_i),
    .trap_cause_i (trap_cause_i),
    .rsp_o        (mach_rsp),
    .mepc_o       (mepc_o),
    .mtvec_o      (mtvec_o)
  );

  csr_debug_bank #(
    .DEBUG (DEBUG)
  ) u_debug_bank (
    .clk    (clk),
    .rst_i  (rst_i),
    .req_i  (csr_req_i),
    .ctrl_i (ctrl_i),
    .rsp_o  (dbg_rsp),
    .dpc_o  (dpc_o)
  );

  // Merge both bank results into the registered response
  csr_resp #(
    .DEBUG (DEBUG)
  ) u_resp (
    .clk     (clk),
    .rst_i   (rst_i),
    .valid_i (csr_req_i.valid),
    .kill_i  (ctrl_i.kill_wb),
    .halt_i  (ctrl_i.halt_wb),
    .mach_i  (mach_rsp),
    .dbg_i   (dbg_rsp),
    .rsp_o   (rsp_o)
  );

endmodule

//--- sim/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

////////////////////////////////////////
// Reference CSR state
////////////////////////////////////////

csr_pkg::csr_data_t mdl_mstatus;
csr_pkg::csr_data_t mdl_mie;
csr_pkg::csr_data_t mdl_mtvec;
csr_pkg::csr_data_t mdl_mscratch;
csr_pkg::csr_data_t mdl_mepc;
csr_pkg::csr_data_t mdl_mcause;
csr_pkg::csr_data_t mdl_dcsr;
csr_pkg::csr_data_t mdl_dpc;
csr_pkg::csr_data_t mdl_dscratch0;
csr_pkg::csr_data_t mdl_dscratch1;

// Response that the DUT must show after the next rising edge
logic               exp_valid;
logic               exp_illegal;
csr_pkg::csr_data_t exp_rdata;

function automatic void reset_csr_state();
  mdl_mstatus   = '0;
  mdl_mie       = '0;
  mdl_mtvec     = MTVEC_RST & 32'hFFFF_FFFC;
  mdl_mscratch  = '0;
  mdl_mepc      = '0;
  mdl_mcause    = '0;
  mdl_dcsr      = 32'h4000_0000;
  mdl_dpc       = '0;
  mdl_dscratch0 = '0;
  mdl_dscratch1 = '0;
  exp_valid     = 1'b0;
  exp_illegal   = 1'b0;
  exp_rdata     = '0;
endfunction

// Returns 1 when the address is mapped, with its current value in val
function automatic logic read_csr(input csr_pkg::csr_addr_t addr,
                                  output csr_pkg::csr_data_t val);
  logic hit;
  hit = 1'b1;
  val = '0;
  case (addr)
    csr_pkg::CSR_MSTATUS:   val = mdl_mstatus;
    csr_pkg::CSR_MIE:       val = mdl_mie;
    csr_pkg::CSR_MTVEC:     val = mdl_mtvec;
    csr_pkg::CSR_MSCRATCH:  val = mdl_mscratch;
    csr_pkg::CSR_MEPC:      val = mdl_mepc;
    csr_pkg::CSR_MCAUSE:    val = mdl_mcause;
    csr_pkg::CSR_DCSR:      val = mdl_dcsr;
    csr_pkg::CSR_DPC:       val = mdl_dpc;
    csr_pkg::CSR_DSCRATCH0: val = mdl_dscratch0;
    csr_pkg::CSR_DSCRATCH1: val = mdl_dscratch1;
    default:                hit = 1'b0;
  endcase
  return hit;
endfunction

// One clock edge of the CSR unit for the inputs present before it
function automatic void apply_cycle(input csr_pkg::csr_req_t req,
                                    input csr_pkg::csr_ctrl_t ctrl,
                                    input csr_pkg::csr_cause_t cause);
  logic               performed;
  logic               hit;
  logic               zero_setclr;
  logic               wr;
  csr_pkg::csr_data_t old;
  csr_pkg::csr_data_t nv;
  performed = req.valid && !ctrl.kill_wb && !ctrl.halt_wb;
  hit       = read_csr(req.addr, old);
  exp_valid = performed;
  if (performed) begin
    exp_illegal = !hit;
    exp_rdata   = hit ? old : '0;
  end
  zero_setclr = ((req.op == csr_pkg::CSR_OP_SET) || (req.op == csr_pkg::CSR_OP_CLEAR)) &&
                (req.wdata == '0);
  wr = performed && hit && (req.op != csr_pkg::CSR_OP_READ) && !zero_setclr;
  case (req.op)
    csr_pkg::CSR_OP_WRITE: nv = req.wdata;
    csr_pkg::CSR_OP_SET:   nv = old | req.wdata;
    csr_pkg::CSR_OP_CLEAR: nv = old & ~req.wdata;
    default:               nv = old;
  endcase

  // MPIE takes MIE on a trap, MIE takes MPIE on mret
  if (ctrl.save_cause)
    mdl_mstatus = {24'b0, mdl_mstatus[3], 7'b0};
  else if (ctrl.restore_mret)
    mdl_mstatus = {24'b0, 1'b1, 3'b0, mdl_mstatus[7], 3'b0};
  else if (wr && req.addr == csr_pkg::CSR_MSTATUS)
    mdl_mstatus = nv & 32'h0000_0088;

  if (ctrl.save_cause) begin
    mdl_mepc   = ctrl.pc & 32'hFFFF_FFFE;
    mdl_mcause = {cause[5], 26'b0, cause[4:0]};
  end else begin
    if (wr && req.addr == csr_pkg::CSR_MEPC)
      mdl_mepc = nv & 32'hFFFF_FFFE;
    if (wr && req.addr == csr_pkg::CSR_MCAUSE)
      mdl_mcause = nv & 32'h8000_001F;
  end
  if (wr && req.addr == csr_pkg::CSR_MIE)
    mdl_mie = nv & 32'h0000_0888;
  if (wr && req.addr == csr_pkg::CSR_MTVEC)
    mdl_mtvec = nv & 32'hFFFF_FFFC;
  if (wr && req.addr == csr_pkg::CSR_MSCRATCH)
    mdl_mscratch = nv;

  // Only ebreakm and step follow a CSR write, the rest of dcsr is kept
  if (ctrl.debug_entry) begin
    mdl_dcsr[8:6] = ctrl.debug_cause;
    mdl_dpc       = ctrl.pc & 32'hFFFF_FFFE;
  end else begin
    if (wr && req.addr == csr_pkg::CSR_DCSR)
      mdl_dcsr = (mdl_dcsr & ~32'h0000_8004) | (nv & 32'h0000_8004);
    if (wr && req.addr == csr_pkg::CSR_DPC)
      mdl_dpc = nv & 32'hFFFF_FFFE;
  end
  if (wr && req.addr == csr_pkg::CSR_DSCRATCH0)
    mdl_dscratch0 = nv;
  if (wr && req.addr == csr_pkg::CSR_DSCRATCH1)
    mdl_dscratch1 = nv;
endfunction

`endif

//--- sim/csr_tb.sv
`timescale 1ns/1ps

module csr_tb;

  localparam int                 NUM_CYCLES = 3000;
  localparam int                 CLK_PERIOD = 4;
  localparam int                 TIMEOUT_NS = (NUM_CYCLES + 2 + 50) * CLK_PERIOD;
  localparam csr_pkg::csr_data_t MTVEC_RST  = 32'h0000_0103;

  logic                clk;
  logic                rst_i;
  csr_pkg::csr_req_t   csr_req;
  csr_pkg::csr_ctrl_t  ctrl;
  csr_pkg::csr_cause_t trap_cause;
  csr_pkg::csr_rsp_t   rsp;
  csr_pkg::csr_data_t  mepc;
  csr_pkg::csr_data_t  mtvec;
  csr_pkg::csr_data_t  dpc;

  integer seed;
  int     error_count;
  int     check_count;

  `include "csr_model.svh"

  csr_unit #(
    .DEBUG     (1'b1),
    .MTVEC_RST (MTVEC_RST)
  ) dut0 (
    .clk          (clk),
    .rst_i        (rst_i),
    .csr_req_i    (csr_req),
    .ctrl_i       (ctrl),
    .trap_cause_i (trap_cause),
    .rsp_o        (rsp),
    .mepc_o       (mepc),
    .mtvec_o      (mtvec),
    .dpc_o        (dpc)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // Indices 0 to 9 are mapped CSRs, the rest are unmapped
  function automatic csr_pkg::csr_addr_t pick_address(int idx);
    csr_pkg::csr_addr_t addr;
    case (idx)
      0:       addr = csr_pkg::CSR_MSTATUS;
      1:       addr = csr_pkg::CSR_MIE;
      2:       addr = csr_pkg::CSR_MTVEC;
      3:       addr = csr_pkg::CSR_MSCRATCH;
      4:       addr = csr_pkg::CSR_MEPC;
      5:       addr = csr_pkg::CSR_MCAUSE;
      6:       addr = csr_pkg::CSR_DCSR;
      7:       addr = csr_pkg::CSR_DPC;
      8:       addr = csr_pkg::CSR_DSCRATCH0;
      9:       addr = csr_pkg::CSR_DSCRATCH1;
      10:      addr = 12'h301;
      11:      addr = 12'h7B4;
      12:      addr = 12'hF14;
      default: addr = 12'h000;
    endcase
    return addr;
  endfunction

  task automatic make_stimulus(input int cycle, output csr_pkg::csr_req_t req,
                               output csr_pkg::csr_ctrl_t ctl,
                               output csr_pkg::csr_cause_t cause);
    logic [31:0] r;
    int          ev;
    r         = $random(seed);
    req.valid = (r[1:0] != 2'b00);
    req.op    = csr_pkg::csr_op_e'(r[3:2]);
    req.addr  = pick_address({$random(seed)} % 14);
    // Zero data now and then exercises set and clear without effect
    req.wdata = (r[6:4] == 3'b000) ? '0 : $random(seed);
    ev               = {$random(seed)} % 16;
    ctl              = '0;
    ctl.kill_wb      = ({$random(seed)} % 16) == 0;
    ctl.halt_wb      = ({$random(seed)} % 16) == 0;
    ctl.save_cause   = (ev == 0);
    ctl.restore_mret = (ev == 1);
    ctl.debug_entry  = ({$random(seed)} % 16) == 0;
    ctl.debug_cause  = r[9:7];
    ctl.pc           = $random(seed);
    cause            = r[15:10];
    // The first cycles read every CSR once from its reset state
    if (cycle < 10) begin
      req = '{valid: 1'b1, op: csr_pkg::CSR_OP_READ, addr: pick_address(cycle), wdata: '0};
      ctl = '0;
    end
  endtask

  ////////////////////////////////////////
  // Checking
  ////////////////////////////////////////

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_outputs();
    check_value("rsp_o.valid", rsp.valid, exp_valid);
    if (exp_valid) begin
      check_value("rsp_o.illegal", rsp.illegal, exp_illegal);
      check_value("rsp_o.rdata", rsp.rdata, exp_rdata);
    end
    check_value("mepc_o", mepc, mdl_mepc);
    check_value("mtvec_o", mtvec, mdl_mtvec);
    check_value("dpc_o", dpc, mdl_dpc);
  endtask

  initial begin
    #(TIMEOUT_NS);
    $display("Watchdog expired after %0d ns before the test sequence ended", TIMEOUT_NS);
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    csr_pkg::csr_req_t   req_n;
    csr_pkg::csr_ctrl_t  ctrl_n;
    csr_pkg::csr_cause_t cause_n;
    csr_pkg::csr_req_t   pend_req;
    csr_pkg::csr_ctrl_t  pend_ctrl;
    csr_pkg::csr_cause_t pend_cause;
    int                  i;
    seed        = 13606;
    error_count = 0;
    check_count = 0;
    rst_i       = 1'b1;
    csr_req     = '0;
    ctrl        = '0;
    trap_cause  = '0;
    pend_req    = '0;
    pend_ctrl   = '0;
    pend_cause  = '0;
    reset_csr_state();
    repeat (2) @(posedge clk);
    rst_i <= 1'b0;

    // The edge after each drive registers the stimulus of the previous cycle
    for (i = 0; i <= NUM_CYCLES; i++) begin
      if (i < NUM_CYCLES) begin
        make_stimulus(i, req_n, ctrl_n, cause_n);
      end else begin
        req_n   = '0;
        ctrl_n  = '0;
        cause_n = '0;
      end
      @(posedge clk);
      csr_req    <= req_n;
      ctrl       <= ctrl_n;
      trap_cause <= cause_n;
      @(negedge clk);
      apply_cycle(pend_req, pend_ctrl, pend_cause);
      check_outputs();
      pend_req   = req_n;
      pend_ctrl  = ctrl_n;
      pend_cause = cause_n;
    end

    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

//--- src.f
+incdir+sim
hw/csr_pkg.sv
hw/csr_machine_bank.sv
hw/csr_debug_bank.sv
hw/csr_resp.sv
hw/csr_unit.sv
sim/csr_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - hw/csr_pkg.sv
      - hw/csr_machine_bank.sv
      - hw/csr_debug_bank.sv
      - hw/csr_resp.sv
      - hw/csr_unit.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/csr_tb.sv
